//--- rtl/qdsp_pkg.sv
package qdsp_pkg;

    localparam int NPROC      = 2;
    localparam int CMD_DEPTH  = 16;
    localparam int ENV_DEPTH  = 256;
    localparam int FREQ_DEPTH = 16;
    localparam int ACQ_DEPTH  = 1024;

    localparam int SAMPLE_W = 16;
    localparam int TIME_W   = 16;

    localparam int CMD_ADDR_W  = $clog2(CMD_DEPTH);
    localparam int ENV_ADDR_W  = $clog2(ENV_DEPTH);
    localparam int FREQ_ADDR_W = $clog2(FREQ_DEPTH);
    localparam int ACQ_ADDR_W  = $clog2(ACQ_DEPTH);

    localparam int CMD_WORDS  = 2;    // 32-bit words per command.
    localparam int MEM_RD_LAT = 2;    // program memory read latency.

    localparam logic [1:0] MEM_CMD  = 2'd0;
    localparam logic [1:0] MEM_ENV  = 2'd1;
    localparam logic [1:0] MEM_FREQ = 2'd2;

    // one period of cosine in Q1.15
    localparam logic signed [15:0] COS_TABLE [16] = '{
        16'sd32767,  16'sd30273,  16'sd23170,  16'sd12539,
        16'sd0,     -16'sd12539, -16'sd23170, -16'sd30273,
        -16'sd32767, -16'sd30273, -16'sd23170, -16'sd12539,
        16'sd0,      16'sd12539,  16'sd23170,  16'sd30273
    };

    typedef struct packed {
        logic        en;
        logic        proc_sel;
        logic [1:0]  mem_sel;
        logic [15:0] addr;
        logic [31:0] data;
    } mem_write_t;

    typedef enum logic [1:0] {
        OP_PULSE = 2'd0,
        OP_END   = 2'd1
    } cmd_op_e;

    typedef struct packed {
        logic [25:0]            pad;
        logic [FREQ_ADDR_W-1:0] freq_addr;
        logic [7:0]             env_len;
        logic [ENV_ADDR_W-1:0]  env_addr;
        logic [TIME_W-1:0]      start_time;
        cmd_op_e                op;    // lowest bits of word 0.
    } cmd_pulse_t;

    typedef struct packed {
        logic [45:0]       pad;
        logic [TIME_W-1:0] stop_time;
        cmd_op_e           op;
    } cmd_stop_t;

    typedef union packed {
        cmd_pulse_t pulse;
        cmd_stop_t  stop;
    } cmd_word_u;

    typedef struct packed {
        logic                  valid;
        logic [ENV_ADDR_W-1:0] env_addr;
        logic [7:0]            env_len;
        logic [31:0]           phase_step;
    } pulse_req_t;

endpackage

//--- rtl/aligned_ram.sv
`timescale 1ns/1ps

module aligned_ram #(
    parameter int DIN_WIDTH       = 32,
    parameter int N_DIN_TO_DOUT   = 1,
    parameter int DOUT_ADDR_WIDTH = 8,
    parameter int READ_LATENCY    = 2
) (
    input  logic                                              clk,
    input  logic [DIN_WIDTH-1:0]                              write_data,
    input  logic [DOUT_ADDR_WIDTH+$clog2(N_DIN_TO_DOUT)-1:0]  write_addr,
    input  logic                                              write_enable,
    input  logic [DOUT_ADDR_WIDTH-1:0]                        read_addr,
    output logic [DIN_WIDTH*N_DIN_TO_DOUT-1:0]                read_data
);

    localparam int N_WORDS    = N_DIN_TO_DOUT * (2 ** DOUT_ADDR_WIDTH);
    localparam int DOUT_WIDTH = DIN_WIDTH * N_DIN_TO_DOUT;

    logic [DIN_WIDTH-1:0]  mem [N_WORDS];
    logic [DOUT_WIDTH-1:0] rd_pipe [READ_LATENCY];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < N_DIN_TO_DOUT; k++) begin
            rd_pipe[0][k*DIN_WIDTH +: DIN_WIDTH] <= mem[read_addr*N_DIN_TO_DOUT + k];  // low word first.
        end
        for (int s = 1; s < READ_LATENCY; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
        end
    end

    assign read_data = rd_pipe[READ_LATENCY-1];

    a_wen_known: assert property (@(posedge clk) !$isunknown(write_enable));

endmodule

//--- rtl/proc_mem_bank.sv
`timescale 1ns/1ps

module proc_mem_bank #(
    parameter int CORE_ID = 0
) (
    input  logic                                clk,
    input  qdsp_pkg::mem_write_t                mem_write,
    input  logic [qdsp_pkg::CMD_ADDR_W-1:0]     cmd_addr,
    output qdsp_pkg::cmd_word_u                 cmd_data,
    input  logic [qdsp_pkg::FREQ_ADDR_W-1:0]    freq_addr,
    output logic [31:0]                         freq_data,
    input  logic [qdsp_pkg::ENV_ADDR_W-1:0]     env_addr,
    output logic signed [qdsp_pkg::SAMPLE_W-1:0] env_data
);

    localparam int CMD_WADDR_W = qdsp_pkg::CMD_ADDR_W + $clog2(qdsp_pkg::CMD_WORDS);

    logic        core_hit;
    logic        cmd_wen;
    logic        env_wen;
    logic        freq_wen;
    logic [31:0] env_word;

    assign core_hit = mem_write.en && (mem_write.proc_sel == 1'(CORE_ID));
    assign cmd_wen  = core_hit && (mem_write.mem_sel == qdsp_pkg::MEM_CMD);
    assign env_wen  = core_hit && (mem_write.mem_sel == qdsp_pkg::MEM_ENV);
    assign freq_wen = core_hit && (mem_write.mem_sel == qdsp_pkg::MEM_FREQ);

    aligned_ram #(.DIN_WIDTH(32), .N_DIN_TO_DOUT(qdsp_pkg::CMD_WORDS),
        .DOUT_ADDR_WIDTH(qdsp_pkg::CMD_ADDR_W), .READ_LATENCY(qdsp_pkg::MEM_RD_LAT))
        cmd_mem (.clk(clk), .write_data(mem_write.data),
            .write_addr(mem_write.addr[CMD_WADDR_W-1:0]), .write_enable(cmd_wen),
            .read_addr(cmd_addr), .read_data(cmd_data));

    aligned_ram #(.DIN_WIDTH(32), .N_DIN_TO_DOUT(1),
        .DOUT_ADDR_WIDTH(qdsp_pkg::FREQ_ADDR_W), .READ_LATENCY(qdsp_pkg::MEM_RD_LAT))
        freq_mem (.clk(clk), .write_data(mem_write.data),
            .write_addr(mem_write.addr[qdsp_pkg::FREQ_ADDR_W-1:0]), .write_enable(freq_wen),
            .read_addr(freq_addr), .read_data(freq_data));

    aligned_ram #(.DIN_WIDTH(32), .N_DIN_TO_DOUT(1),
        .DOUT_ADDR_WIDTH(qdsp_pkg::ENV_ADDR_W), .READ_LATENCY(qdsp_pkg::MEM_RD_LAT))
        env_mem (.clk(clk), .write_data(mem_write.data),
            .write_addr(mem_write.addr[qdsp_pkg::ENV_ADDR_W-1:0]), .write_enable(env_wen),
            .read_addr(env_addr), .read_data(env_word));

    assign env_data = env_word[qdsp_pkg::SAMPLE_W-1:0];    // sample sits in the low half.

endmodule

//--- rtl/pulse_sequencer.sv
`timescale 1ns/1ps

module pulse_sequencer (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             stb_start,
    output logic [qdsp_pkg::CMD_ADDR_W-1:0]  cmd_addr,
    input  qdsp_pkg::cmd_word_u              cmd_data,
    output logic [qdsp_pkg::FREQ_ADDR_W-1:0] freq_addr,
    input  logic [31:0]                      freq_data,
    output qdsp_pkg::pulse_req_t             pulse_req,
    output logic                             done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CMD,
        S_FREQ,
        S_WAIT,
        S_END
    } state_e;

    state_e                          state;
    logic [qdsp_pkg::TIME_W-1:0]     time_cnt;
    logic [qdsp_pkg::CMD_ADDR_W-1:0] cmd_ptr;
    logic [1:0]                      lat_cnt;
    logic                            rd_ready;
    qdsp_pkg::cmd_word_u             cmd_reg;
    logic [31:0]                     step_reg;

    assign rd_ready  = (lat_cnt == 2'(qdsp_pkg::MEM_RD_LAT));
    assign cmd_addr  = cmd_ptr;
    assign freq_addr = cmd_reg.pulse.freq_addr;
    assign done      = (state == S_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            time_cnt  <= '0;
            cmd_ptr   <= '0;
            lat_cnt   <= '0;
            pulse_req <= '0;
        end else begin
            pulse_req.valid <= 1'b0;    // one-cycle strobe.
            if (state != S_IDLE) begin
                time_cnt <= time_cnt + 1'b1;
            end
            if (stb_start) begin    // also restarts a run in progress.
                state    <= S_CMD;
                time_cnt <= '0;
                cmd_ptr  <= '0;
                lat_cnt  <= '0;
            end else begin
                unique case (state)
                    S_CMD: begin
                        lat_cnt <= lat_cnt + 1'b1;
                        if (rd_ready) begin
                            lat_cnt <= '0;
                            state   <= (cmd_data.pulse.op == qdsp_pkg::OP_PULSE) ? S_FREQ : S_END;
                        end
                    end
                    S_FREQ: begin
                        lat_cnt <= lat_cnt + 1'b1;
                        if (rd_ready) begin
                            lat_cnt <= '0;
                            state   <= S_WAIT;
                        end
                    end
                    S_WAIT: begin
                        if (time_cnt == cmd_reg.pulse.start_time) begin
                            pulse_req.valid      <= 1'b1;
                            pulse_req.env_addr   <= cmd_reg.pulse.env_addr;
                            pulse_req.env_len    <= cmd_reg.pulse.env_len;
                            pulse_req.phase_step <= step_reg;
                            cmd_ptr              <= cmd_ptr + 1'b1;
                            state                <= S_CMD;
                        end
                    end
                    S_END: begin
                        // a stop time already passed ends the run at once.
                        if (time_cnt >= cmd_reg.stop.stop_time) begin
                            state <= S_IDLE;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_CMD && rd_ready) begin
            cmd_reg <= cmd_data;
        end
        if (state == S_FREQ && rd_ready) begin
            step_reg <= freq_data;
        end
    end

    a_req_single: assert property (@(posedge clk) disable iff (!arst_n)
        pulse_req.valid |=> !pulse_req.valid);

endmodule

//--- rtl/pulse_synth.sv
`timescale 1ns/1ps

module pulse_synth (
    input  logic                                clk,
    input  logic                                arst_n,
    input  qdsp_pkg::pulse_req_t                pulse_req,
    output logic [qdsp_pkg::ENV_ADDR_W-1:0]     env_addr,
    input  logic signed [qdsp_pkg::SAMPLE_W-1:0] env_data,
    output logic signed [qdsp_pkg::SAMPLE_W-1:0] sample,
    output logic                                busy
);

    logic [7:0]                          remaining;
    logic                                rd_active;
    logic                                act_d1;
    logic                                act_d2;
    logic                                act_mul;
    logic [qdsp_pkg::ENV_ADDR_W-1:0]     addr_reg;
    logic [31:0]                         phase_reg;
    logic [31:0]                         phase_cur;
    logic [31:0]                         step_reg;
    logic [31:0]                         step_cur;
    logic [3:0]                          cos_idx_d1;
    logic [3:0]                          cos_idx_d2;
    logic signed [2*qdsp_pkg::SAMPLE_W-1:0] product;

    // the request cycle reads sample 0 directly.
    assign rd_active = pulse_req.valid ? (pulse_req.env_len != '0) : (remaining != '0);
    assign env_addr  = pulse_req.valid ? pulse_req.env_addr : addr_reg;
    assign phase_cur = pulse_req.valid ? '0 : phase_reg;
    assign step_cur  = pulse_req.valid ? pulse_req.phase_step : step_reg;
    assign product   = env_data * qdsp_pkg::COS_TABLE[cos_idx_d2];
    assign busy      = (remaining != '0) | act_d1 | act_d2 | act_mul;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            remaining <= '0;
            act_d1    <= 1'b0;
            act_d2    <= 1'b0;
            act_mul   <= 1'b0;
            sample    <= '0;
        end else begin
            act_d1  <= rd_active;    // tracks the envelope read latency.
            act_d2  <= act_d1;
            act_mul <= act_d2;
            sample  <= act_d2 ? product[30:15] : '0;
            if (pulse_req.valid) begin
                remaining <= (pulse_req.env_len != '0) ? pulse_req.env_len - 1'b1 : '0;
            end else if (remaining != '0) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_reg   <= env_addr + 1'b1;
        phase_reg  <= phase_cur + step_cur;
        step_reg   <= step_cur;
        cos_idx_d1 <= phase_cur[31:28];    // top phase bits index the table.
        cos_idx_d2 <= cos_idx_d1;
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        pulse_req.valid |-> !busy);

endmodule

//--- rtl/dac_combiner.sv
`timescale 1ns/1ps

module dac_combiner (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic signed [qdsp_pkg::SAMPLE_W-1:0] core_samples [qdsp_pkg::NPROC],
    output logic signed [qdsp_pkg::SAMPLE_W-1:0] dac
);

    localparam int SUM_W = qdsp_pkg::SAMPLE_W + $clog2(qdsp_pkg::NPROC);
    localparam logic signed [SUM_W-1:0] SAT_MAX = (2 ** (qdsp_pkg::SAMPLE_W - 1)) - 1;
    localparam logic signed [SUM_W-1:0] SAT_MIN = -(2 ** (qdsp_pkg::SAMPLE_W - 1));

    logic signed [SUM_W-1:0] sum;

    always_comb begin
        sum = '0;
        for (int i = 0; i < qdsp_pkg::NPROC; i++) begin
            sum = sum + core_samples[i];    // sign extends to the wide sum.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dac <= '0;
        end else if (sum > SAT_MAX) begin
            dac <= SAT_MAX[qdsp_pkg::SAMPLE_W-1:0];
        end else if (sum < SAT_MIN) begin
            dac <= SAT_MIN[qdsp_pkg::SAMPLE_W-1:0];
        end else begin
            dac <= sum[qdsp_pkg::SAMPLE_W-1:0];
        end
    end

endmodule

//--- rtl/acq_capture.sv
`timescale 1ns/1ps

module acq_capture (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                stb_start,
    input  logic signed [qdsp_pkg::SAMPLE_W-1:0] adc,
    input  logic [qdsp_pkg::ACQ_ADDR_W-1:0]     buf_read_addr,
    output logic signed [qdsp_pkg::SAMPLE_W-1:0] acq_read_data
);

    logic [qdsp_pkg::ACQ_ADDR_W-1:0] wr_addr;
    logic                            wr_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else if (stb_start) begin
            wr_en   <= 1'b1;    // sample 0 lands in the next cycle.
            wr_addr <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
            if (wr_addr == qdsp_pkg::ACQ_ADDR_W'(qdsp_pkg::ACQ_DEPTH - 1)) begin
                wr_en <= 1'b0;    // buffer full.
            end
        end
    end

    aligned_ram #(.DIN_WIDTH(qdsp_pkg::SAMPLE_W), .N_DIN_TO_DOUT(1),
        .DOUT_ADDR_WIDTH(qdsp_pkg::ACQ_ADDR_W), .READ_LATENCY(1))
        acq_buf (.clk(clk), .write_data(adc), .write_addr(wr_addr),
            .write_enable(wr_en), .read_addr(buf_read_addr), .read_data(acq_read_data));

endmodule

//--- rtl/dsp_sim_toplevel.sv
`timescale 1ns/1ps

module dsp_sim_toplevel (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                stb_start,
    input  qdsp_pkg::mem_write_t                mem_write,
    input  logic [qdsp_pkg::ACQ_ADDR_W-1:0]     buf_read_addr,
    input  logic signed [qdsp_pkg::SAMPLE_W-1:0] adc,
    output logic signed [qdsp_pkg::SAMPLE_W-1:0] dac,
    output logic signed [qdsp_pkg::SAMPLE_W-1:0] acq_read_data,
    output logic                                running
);

    logic signed [qdsp_pkg::SAMPLE_W-1:0] core_samples [qdsp_pkg::NPROC];
    logic [qdsp_pkg::NPROC-1:0]           done;
    logic [qdsp_pkg::NPROC-1:0]           busy;

    for (genvar i = 0; i < qdsp_pkg::NPROC; i++) begin : g_core
        logic [qdsp_pkg::CMD_ADDR_W-1:0]      cmd_addr;
        qdsp_pkg::cmd_word_u                  cmd_data;
        logic [qdsp_pkg::FREQ_ADDR_W-1:0]     freq_addr;
        logic [31:0]                          freq_data;
        logic [qdsp_pkg::ENV_ADDR_W-1:0]      env_addr;
        logic signed [qdsp_pkg::SAMPLE_W-1:0] env_data;
        qdsp_pkg::pulse_req_t                 pulse_req;

        proc_mem_bank #(.CORE_ID(i)) bank (
            .clk(clk), .mem_write(mem_write),
            .cmd_addr(cmd_addr), .cmd_data(cmd_data),
            .freq_addr(freq_addr), .freq_data(freq_data),
            .env_addr(env_addr), .env_data(env_data));

        pulse_sequencer seq (
            .clk(clk), .arst_n(arst_n), .stb_start(stb_start),
            .cmd_addr(cmd_addr), .cmd_data(cmd_data),
            .freq_addr(freq_addr), .freq_data(freq_data),
            .pulse_req(pulse_req), .done(done[i]));

        pulse_synth synth (
            .clk(clk), .arst_n(arst_n), .pulse_req(pulse_req),
            .env_addr(env_addr), .env_data(env_data),
            .sample(core_samples[i]), .busy(busy[i]));
    end

    dac_combiner combiner (
        .clk(clk), .arst_n(arst_n), .core_samples(core_samples), .dac(dac));

    acq_capture capture (
        .clk(clk), .arst_n(arst_n), .stb_start(stb_start), .adc(adc),
        .buf_read_addr(buf_read_addr), .acq_read_data(acq_read_data));

    assign running = (~&done) | (|busy);    // holds until the last pulse drains.

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- tests/dsp_sim_tb.sv
`timescale 1ns/1ps

module dsp_sim_tb;

    localparam int MODEL_LEN   = 2048;
    localparam int MAX_PULSES  = 4;
    localparam int RUN_TIMEOUT = 64;
    localparam int N_READS     = 64;

    logic                                 clk;
    logic                                 arst_n;
    logic                                 stb_start;
    qdsp_pkg::mem_write_t                 mem_write;
    logic [qdsp_pkg::ACQ_ADDR_W-1:0]      buf_read_addr;
    logic signed [qdsp_pkg::SAMPLE_W-1:0] adc;
    logic signed [qdsp_pkg::SAMPLE_W-1:0] dac;
    logic signed [qdsp_pkg::SAMPLE_W-1:0] acq_read_data;
    logic                                 running;

    integer seed;
    int     run_cycle;

    logic signed [15:0] env_model [qdsp_pkg::NPROC][qdsp_pkg::ENV_DEPTH];
    logic [31:0]        freq_model [qdsp_pkg::NPROC][qdsp_pkg::FREQ_DEPTH];
    int                 n_pulses [qdsp_pkg::NPROC];
    int                 p_start [qdsp_pkg::NPROC][MAX_PULSES];
    int                 p_addr [qdsp_pkg::NPROC][MAX_PULSES];
    int                 p_len [qdsp_pkg::NPROC][MAX_PULSES];
    int                 p_freq [qdsp_pkg::NPROC][MAX_PULSES];
    int                 stop_time [qdsp_pkg::NPROC];
    int                 exp_dac [MODEL_LEN];
    logic signed [15:0] adc_samples [qdsp_pkg::ACQ_DEPTH];

    tb_clock #(.PERIOD_NS(8)) clock_gen (.clk(clk));

    dsp_sim_toplevel UUT (
        .clk(clk), .arst_n(arst_n), .stb_start(stb_start), .mem_write(mem_write),
        .buf_read_addr(buf_read_addr), .adc(adc), .dac(dac),
        .acq_read_data(acq_read_data), .running(running));

    function automatic int rand_between(int lo, int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // envelope times cosine at phase k*step in Q1.15.
    function automatic int cos_times_env(logic signed [15:0] env, logic [31:0] step, int k);
        logic [31:0] phase;
        int          product;
        phase   = step * k;
        product = int'(env) * int'(qdsp_pkg::COS_TABLE[phase[31:28]]);
        return product >>> 15;
    endfunction

    function automatic int saturate16(int value);
        if (value > 32767) begin
            return 32767;
        end
        if (value < -32768) begin
            return -32768;
        end
        return value;
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        string msg;
        assert (actual === expected) else begin
            msg = $sformatf("FAIL time %0t: %s expected %0d, got %0d",
                            $time, name, expected, actual);
            stop_with_error(msg);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input int core, input logic [1:0] sel, input int addr,
                              input logic [31:0] data);
        mem_write.en       = 1'b1;
        mem_write.proc_sel = core[0];
        mem_write.mem_sel  = sel;
        mem_write.addr     = addr[15:0];
        mem_write.data     = data;
        next_cycle();
        mem_write.en = 1'b0;
    endtask

    task automatic check_idle(input int n_cycles);
        repeat (n_cycles) begin
            next_cycle();
            check_value("dac", 0, dac);
            check_value("running", 0, running);
        end
    endtask

    task automatic build_program();
        int t;
        int slot_end;
        for (int k = 0; k < qdsp_pkg::NPROC; k++) begin
            for (int a = 0; a < qdsp_pkg::ENV_DEPTH; a++) begin
                env_model[k][a] = 16'($random(seed));
            end
            for (int f = 0; f < qdsp_pkg::FREQ_DEPTH; f++) begin
                if (f < 4) begin
                    freq_model[k][f] = $random(seed) >> 8;    // slow steps stay near cos 1.
                end else begin
                    freq_model[k][f] = $random(seed);
                end
            end
            n_pulses[k] = rand_between(2, 4);
        end
        // both cores share start times so pulses overlap on the DAC
        t = rand_between(6, 9);
        for (int j = 0; j < MAX_PULSES; j++) begin
            slot_end = t;
            for (int k = 0; k < qdsp_pkg::NPROC; k++) begin
                if (j < n_pulses[k]) begin
                    p_len[k][j]   = rand_between(1, 64);
                    p_addr[k][j]  = rand_between(0, qdsp_pkg::ENV_DEPTH - p_len[k][j]);
                    p_freq[k][j]  = rand_between(0, qdsp_pkg::FREQ_DEPTH - 1);
                    p_start[k][j] = t;
                    if (t + p_len[k][j] > slot_end) begin
                        slot_end = t + p_len[k][j];
                    end
                    stop_time[k] = t + p_len[k][j] + 6 + rand_between(0, 7);
                end
            end
            t = slot_end + 6 + rand_between(0, 5);
        end
        // first samples of the first two slots play at cos 1 and push the sum past the rails.
        for (int k = 0; k < qdsp_pkg::NPROC; k++) begin
            env_model[k][p_addr[k][0]] = 16'sh7800;
            if (p_addr[k][1] != p_addr[k][0]) begin
                env_model[k][p_addr[k][1]] = -16'sh7800;
            end
        end
        for (int c = 0; c < qdsp_pkg::ACQ_DEPTH; c++) begin
            adc_samples[c] = 16'($random(seed));
        end
    endtask

    task automatic load_memories();
        qdsp_pkg::cmd_word_u cw;
        for (int k = 0; k < qdsp_pkg::NPROC; k++) begin
            for (int a = 0; a < qdsp_pkg::ENV_DEPTH; a++) begin
                write_word(k, qdsp_pkg::MEM_ENV, a, {16'($random(seed)), env_model[k][a]});
            end
            for (int f = 0; f < qdsp_pkg::FREQ_DEPTH; f++) begin
                write_word(k, qdsp_pkg::MEM_FREQ, f, freq_model[k][f]);
            end
            for (int j = 0; j <= n_pulses[k]; j++) begin
                cw = '0;
                if (j < n_pulses[k]) begin
                    cw.pulse.op         = qdsp_pkg::OP_PULSE;
                    cw.pulse.start_time = 16'(p_start[k][j]);
                    cw.pulse.env_addr   = 8'(p_addr[k][j]);
                    cw.pulse.env_len    = 8'(p_len[k][j]);
                    cw.pulse.freq_addr  = 4'(p_freq[k][j]);
                end else begin
                    cw.stop.op        = qdsp_pkg::OP_END;
                    cw.stop.stop_time = 16'(stop_time[k]);
                end
                write_word(k, qdsp_pkg::MEM_CMD, 2 * j, cw[31:0]);    // word 0 is the low half.
                write_word(k, qdsp_pkg::MEM_CMD, 2 * j + 1, cw[63:32]);
            end
        end
    endtask

    task automatic build_model();
        int core_out [qdsp_pkg::NPROC][MODEL_LEN];
        int total;
        for (int k = 0; k < qdsp_pkg::NPROC; k++) begin
            for (int c = 0; c < MODEL_LEN; c++) begin
                core_out[k][c] = 0;
            end
            for (int j = 0; j < n_pulses[k]; j++) begin
                for (int i = 0; i < p_len[k][j]; i++) begin
                    // first sample reaches the DAC five counts after the start time.
                    core_out[k][p_start[k][j] + 5 + i] = cos_times_env(
                        env_model[k][p_addr[k][j] + i], freq_model[k][p_freq[k][j]], i);
                end
            end
        end
        for (int c = 0; c < MODEL_LEN; c++) begin
            total = 0;
            for (int k = 0; k < qdsp_pkg::NPROC; k++) begin
                total += core_out[k][c];
            end
            exp_dac[c] = saturate16(total);
        end
    endtask

    task automatic drive_and_check();
        if (run_cycle < qdsp_pkg::ACQ_DEPTH) begin
            adc = adc_samples[run_cycle];
        end
        check_value("dac", exp_dac[run_cycle], dac);
    endtask

    task automatic run_program();
        int max_stop;
        max_stop = 0;
        for (int k = 0; k < qdsp_pkg::NPROC; k++) begin
            if (stop_time[k] > max_stop) begin
                max_stop = stop_time[k];
            end
        end
        stb_start = 1'b1;
        next_cycle();
        stb_start = 1'b0;
        run_cycle = 0;    // counter reads 0 in this cycle.
        check_value("running", 1, running);
        while (running === 1'b1) begin
            assert (run_cycle <= max_stop + RUN_TIMEOUT) else
                stop_with_error("timeout: running stayed high after the last stop time");
            drive_and_check();
            next_cycle();
            run_cycle++;
        end
        assert (run_cycle > max_stop) else
            stop_with_error("running fell before the last stop time was reached");
        while (run_cycle < qdsp_pkg::ACQ_DEPTH + 2) begin    // fill the capture buffer.
            drive_and_check();
            next_cycle();
            run_cycle++;
        end
    endtask

    task automatic read_back();
        int addr;
        repeat (N_READS) begin
            addr          = rand_between(0, qdsp_pkg::ACQ_DEPTH - 1);
            buf_read_addr = addr[qdsp_pkg::ACQ_ADDR_W-1:0];
            next_cycle();
            check_value("acq_read_data", adc_samples[addr], acq_read_data);
        end
    endtask

    initial begin
        seed          = 32'h72f7a100;
        arst_n        = 1'b0;
        stb_start     = 1'b0;
        mem_write     = '0;
        buf_read_addr = '0;
        adc           = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_idle(3);
        build_program();
        load_memories();
        check_idle(2);
        build_model();
        run_program();
        read_back();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- list.f
rtl/qdsp_pkg.sv
rtl/aligned_ram.sv
rtl/proc_mem_bank.sv
rtl/pulse_sequencer.sv
rtl/pulse_synth.sv
rtl/dac_combiner.sv
rtl/acq_capture.sv
rtl/dsp_sim_toplevel.sv
tests/tb_clock.sv
tests/dsp_sim_tb.sv

//--- Bender.yml
package:
  name: qdsp_sim

sources:
  - files:
      - rtl/qdsp_pkg.sv
      - rtl/aligned_ram.sv
      - rtl/proc_mem_bank.sv
      - rtl/pulse_sequencer.sv
      - rtl/pulse_synth.sv
      - rtl/dac_combiner.sv
      - rtl/acq_capture.sv
      - rtl/dsp_sim_toplevel.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/dsp_sim_tb.sv
